/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= opcode_decoder_tb
RTL_TOP   ?= opcode_decoder
FILELIST  ?= opcode_decoder.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/100ps
RTL_SRCS  ?= common/cpu6502_pkg.sv decode/addr_mode_decode.sv decode/exec_op_decode.sv \
	decode/access_info_decode.sv src/opcode_decoder.sv
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* common/cpu6502_pkg.sv */
package cpu6502_pkg;

	// Instruction set selector, opcode bits [1:0]
	localparam logic [1:0] set_ctl = 2'b00;
	localparam logic [1:0] set_alu = 2'b01;
	localparam logic [1:0] set_rmw = 2'b10;

	// Opcode layout aaabbbcc
	typedef struct packed {
		logic [2:0] group_op;  // Operation within the set
		logic [2:0] mode;      // Addressing field
		logic [1:0] set_sel;
	} opcode_fields_t;

	// Exceptions match the whole byte, regular opcodes the fields
	typedef union packed {
		logic [7:0]     raw;
		opcode_fields_t fields;
	} opcode_u;

	typedef enum logic [3:0] {
		addr_none,      // Implied or accumulator
		addr_abs,
		addr_abs_x,
		addr_abs_y,
		addr_relative,
		addr_immed,
		addr_indir,
		addr_index_x,   // (zp,X)
		addr_index_y,   // (zp),Y
		addr_zero,
		addr_zero_x,
		addr_zero_y,
		addr_illegal
	} addr_mode_t;

	typedef enum logic [6:0] {
		// Set 01, in group_op order
		op_ora, op_and, op_eor, op_adc, op_sta, op_lda, op_cmp, op_sbc,
		// Set 10, accumulator forms four codes above the memory forms
		op_asl, op_rol, op_lsr, op_ror, op_asla, op_rola, op_lsra, op_rora,
		op_stx, op_ldx, op_dec, op_inc,
		op_sty, op_ldy, op_bit, op_cpy, op_cpx,
		op_brk, op_bcc, op_bcs, op_beq, op_bmi, op_bne, op_bpl, op_bvc, op_bvs,
		op_jmp, op_jsr, op_rts, op_rti,
		op_php, op_plp, op_pha, op_pla,
		op_dey, op_tay, op_iny, op_inx,
		op_clc, op_sec, op_cli, op_sei, op_tya, op_clv, op_cld, op_sed,
		op_txa, op_txs, op_tax, op_tsx, op_dex, op_nop,
		op_illegal
	} exec_op_t;

	typedef struct packed {
		logic mem_read;    // Operand must be read from memory
		logic page_cross;  // Extra cycle when the index crosses a page
	} access_info_t;

	typedef struct packed {
		addr_mode_t   addr_mode;
		exec_op_t     exec_op;
		access_info_t info;
	} decode_t;

endpackage

/* decode/access_info_decode.sv */
`timescale 1ns/100ps

module access_info_decode
	import cpu6502_pkg::*;
(
	input  logic         CLK,
	input  logic         rst_n,
	input  opcode_u      opcode,
	output access_info_t info
);

	opcode_fields_t f;
	access_info_t   info_next;

	assign f = opcode.fields;

	always_comb begin
		info_next = '0;
		case (f.set_sel)
		set_alu:
			if (f.group_op != 3'd4) begin  // STA reads nothing
				info_next.mem_read = 1'b1;
				// (zp),Y  abs,Y  abs,X
				info_next.page_cross = f.mode == 3'd4 || f.mode[2:1] == 2'b11;
			end
		set_rmw: begin
			info_next.mem_read = f.group_op != 3'd4 &&
				(f.mode[0] || (f.mode == 3'd0 && f.group_op == 3'd5));
			info_next.page_cross = f.group_op == 3'd5 && f.mode == 3'd7;  // LDX abs,Y only
		end
		set_ctl:
			case (f.mode)
			3'd0: info_next.mem_read = f.group_op >= 3'd5;
			3'd1, 3'd3: info_next.mem_read = f.group_op == 3'd1 || f.group_op >= 3'd5;
			3'd4: info_next = 2'b11;  // Branch offset, target may cross
			3'd5: info_next.mem_read = f.group_op == 3'd5;
			3'd7: info_next = {2{f.group_op == 3'd5}};  // LDY abs,X
			default: info_next = '0;
			endcase
		default: info_next = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n)
			info <= '0;
		else
			info <= info_next;
	end

endmodule

/* decode/addr_mode_decode.sv */
`timescale 1ns/100ps

module addr_mode_decode
	import cpu6502_pkg::*;
(
	input  logic       CLK,
	input  logic       rst_n,
	input  opcode_u    opcode,
	output addr_mode_t addr_mode
);

	opcode_fields_t f;
	addr_mode_t     alu_mode;
	addr_mode_t     ctl_mode;
	logic           field_ok;
	addr_mode_t     mode_next;

	assign f = opcode.fields;

	always_comb begin
		case (f.mode)
		3'd0: alu_mode = addr_index_x;
		3'd1: alu_mode = addr_zero;
		3'd2: alu_mode = addr_immed;
		3'd3: alu_mode = addr_abs;
		3'd4: alu_mode = addr_index_y;
		3'd5: alu_mode = addr_zero_x;
		3'd6: alu_mode = addr_abs_y;
		default: alu_mode = addr_abs_x;
		endcase
	end

	// Mode field shared by sets 10 and 00
	always_comb begin
		case (f.mode)
		3'd0: ctl_mode = addr_immed;
		3'd1: ctl_mode = addr_zero;
		3'd3: ctl_mode = addr_abs;
		3'd4: ctl_mode = addr_relative;
		3'd5: ctl_mode = addr_zero_x;
		3'd7: ctl_mode = addr_abs_x;
		default: ctl_mode = addr_none;  // Single byte columns 2 and 6
		endcase
		// STX and LDX index with Y
		if (f.set_sel == set_rmw && f.group_op[2:1] == 2'b10) begin
			if (f.mode == 3'd5)
				ctl_mode = addr_zero_y;
			else if (f.mode == 3'd7)
				ctl_mode = addr_abs_y;
		end
	end

	// Field combinations that hold a documented instruction
	always_comb begin
		field_ok = 1'b0;
		case (f.set_sel)
		set_alu: field_ok = !(f.group_op == 3'd4 && f.mode == 3'd2);  // No STA #
		set_rmw:
			case (f.mode)
			3'd1, 3'd2, 3'd3, 3'd5: field_ok = 1'b1;
			3'd6: field_ok = f.group_op[2:1] == 2'b10;  // TXS, TSX
			3'd7: field_ok = f.group_op != 3'd4;
			default: field_ok = 1'b0;
			endcase
		set_ctl:
			case (f.mode)
			3'd0: field_ok = f.group_op >= 3'd5;
			3'd1: field_ok = f.group_op == 3'd1 || f.group_op >= 3'd4;
			3'd2, 3'd4, 3'd6: field_ok = 1'b1;
			3'd3: field_ok = f.group_op != 3'd0;
			3'd5: field_ok = f.group_op[2:1] == 2'b10;
			3'd7: field_ok = f.group_op == 3'd5;
			default: field_ok = 1'b0;
			endcase
		default: field_ok = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode.raw)
		8'h20: mode_next = addr_abs;    // JSR
		8'h6c: mode_next = addr_indir;  // JMP (ind)
		8'h00, 8'h40, 8'h60: mode_next = addr_none;  // BRK, RTI, RTS
		8'ha2: mode_next = addr_immed;  // LDX #
		default:
			if (!field_ok)
				mode_next = addr_illegal;
			else if (f.set_sel == set_alu)
				mode_next = alu_mode;
			else
				mode_next = ctl_mode;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n)
			addr_mode <= addr_none;
		else
			addr_mode <= mode_next;
	end

endmodule

/* decode/exec_op_decode.sv */
`timescale 1ns/100ps

module exec_op_decode
	import cpu6502_pkg::*;
(
	input  logic     CLK,
	input  logic     rst_n,
	input  opcode_u  opcode,
	output exec_op_t exec_op
);

	opcode_fields_t f;
	exec_op_t       rmw_op;
	exec_op_t       ctl_op;
	exec_op_t       branch_op;
	logic           rmw_ok;
	logic           ctl_ok;
	exec_op_t       op_next;

	assign f = opcode.fields;

	always_comb begin
		case (f.group_op)
		3'd0: rmw_op = op_asl;
		3'd1: rmw_op = op_rol;
		3'd2: rmw_op = op_lsr;
		3'd3: rmw_op = op_ror;
		3'd4: rmw_op = op_stx;
		3'd5: rmw_op = op_ldx;
		3'd6: rmw_op = op_dec;
		default: rmw_op = op_inc;
		endcase
		case (f.mode)
		3'd0: rmw_ok = f.group_op == 3'd5;  // LDX #
		3'd1, 3'd3, 3'd5: rmw_ok = 1'b1;
		3'd7: rmw_ok = f.group_op != 3'd4;
		default: rmw_ok = 1'b0;
		endcase
	end

	always_comb begin
		case (f.group_op)
		3'd1: ctl_op = op_bit;
		3'd2, 3'd3: ctl_op = op_jmp;
		3'd4: ctl_op = op_sty;
		3'd5: ctl_op = op_ldy;
		3'd6: ctl_op = op_cpy;
		3'd7: ctl_op = op_cpx;
		default: ctl_op = op_illegal;
		endcase
		case (f.mode)
		3'd0: ctl_ok = f.group_op >= 3'd5;
		3'd1: ctl_ok = f.group_op == 3'd1 || f.group_op >= 3'd4;
		3'd3: ctl_ok = f.group_op != 3'd0;
		3'd5: ctl_ok = f.group_op[2:1] == 2'b10;
		3'd7: ctl_ok = f.group_op == 3'd5;
		default: ctl_ok = 1'b0;
		endcase
	end

	// Top two bits pick the flag, bit 5 the value branched on
	always_comb begin
		case (f.group_op[2:1])
		2'b00: branch_op = f.group_op[0] ? op_bmi : op_bpl;  // N
		2'b01: branch_op = f.group_op[0] ? op_bvs : op_bvc;  // V
		2'b10: branch_op = f.group_op[0] ? op_bcs : op_bcc;  // C
		default: branch_op = f.group_op[0] ? op_beq : op_bne;  // Z
		endcase
	end

	always_comb begin
		op_next = op_illegal;
		case (opcode.raw)
		8'h00: op_next = op_brk;
		8'h20: op_next = op_jsr;
		8'h40: op_next = op_rti;
		8'h60: op_next = op_rts;
		8'h08: op_next = op_php;
		8'h28: op_next = op_plp;
		8'h48: op_next = op_pha;
		8'h68: op_next = op_pla;
		8'h88: op_next = op_dey;
		8'ha8: op_next = op_tay;
		8'hc8: op_next = op_iny;
		8'he8: op_next = op_inx;
		8'h18: op_next = op_clc;
		8'h38: op_next = op_sec;
		8'h58: op_next = op_cli;
		8'h78: op_next = op_sei;
		8'h98: op_next = op_tya;
		8'hb8: op_next = op_clv;
		8'hd8: op_next = op_cld;
		8'hf8: op_next = op_sed;
		8'h8a: op_next = op_txa;
		8'h9a: op_next = op_txs;
		8'haa: op_next = op_tax;
		8'hba: op_next = op_tsx;
		8'hca: op_next = op_dex;
		8'hea: op_next = op_nop;
		default:
			case (f.set_sel)
			set_alu:
				if (!(f.group_op == 3'd4 && f.mode == 3'd2))
					op_next = exec_op_t'({4'd0, f.group_op});
			set_rmw:
				if (f.mode == 3'd2 && !f.group_op[2])
					op_next = exec_op_t'(rmw_op + 7'd4);  // ASLA .. RORA
				else if (rmw_ok)
					op_next = rmw_op;
			set_ctl:
				if (f.mode == 3'd4)
					op_next = branch_op;
				else if (ctl_ok)
					op_next = ctl_op;
			default: op_next = op_illegal;
			endcase
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n)
			exec_op <= op_nop;
		else
			exec_op <= op_next;
	end

endmodule

/* opcode_decoder.f */
common/cpu6502_pkg.sv
decode/addr_mode_decode.sv
decode/exec_op_decode.sv
decode/access_info_decode.sv
src/opcode_decoder.sv
tb/opcode_decoder_tb.sv

/* src/opcode_decoder.sv */
`timescale 1ns/100ps

module opcode_decoder
	import cpu6502_pkg::*;
(
	input  logic    CLK,
	input  logic    rst_n,
	input  opcode_u opcode,
	output decode_t decode
);

	addr_mode_t   addr_mode;
	exec_op_t     exec_op;
	access_info_t info;

	addr_mode_decode addr_mode_decode0 (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.opcode    (opcode),
		.addr_mode (addr_mode)
	);

	exec_op_decode exec_op_decode0 (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.opcode  (opcode),
		.exec_op (exec_op)
	);

	access_info_decode access_info_decode0 (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.opcode (opcode),
		.info   (info)
	);

	assign decode = '{addr_mode: addr_mode, exec_op: exec_op, info: info};

endmodule

/* tb/opcode_decoder_tb.sv */
`timescale 1ns/100ps

module opcode_decoder_tb
	import cpu6502_pkg::*;
;

	localparam int max_vectors = 64;
	localparam int reset_cycles = 8;

	logic    CLK;
	logic    rst_n;
	opcode_u opcode;
	decode_t decode;

	// Vector word: opcode[23:16] mode[15:12] operation[11:4] flags[3:0]
	logic [23:0] vectors [max_vectors];
	int          n_vectors = 0;
	int          mismatches = 0;  // Per test, cleared before each one
	int          pass_count = 0;
	int          fail_count = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;  // Replaced once the vectors are counted

	opcode_decoder dut0 (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.opcode (opcode),
		.decode (decode)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic mode_compare(input addr_mode_t expected, input addr_mode_t actual);
		if (actual !== expected) begin
			$display("Error: decode.addr_mode expected %h, got %h", expected, actual);
			mismatches++;
		end
	endtask

	task automatic op_compare(input exec_op_t expected, input exec_op_t actual);
		if (actual !== expected) begin
			$display("Error: decode.exec_op expected %h, got %h", expected, actual);
			mismatches++;
		end
	endtask

	task automatic info_compare(input access_info_t expected, input access_info_t actual);
		if (actual !== expected) begin
			$display("Error: decode.info expected %h, got %h", expected, actual);
			mismatches++;
		end
	endtask

	task automatic tally(input string name);
		if (mismatches == 0) begin
			$display("%s: pass", name);
			pass_count++;
		end else begin
			$display("%s: FAIL, %0d field(s) wrong", name, mismatches);
			fail_count++;
		end
	endtask

	// Compares decode against vector idx, driven one edge earlier
	task automatic score_vector(input int idx);
		logic [23:0] v;
		v = vectors[idx];
		mismatches = 0;
		mode_compare(addr_mode_t'(v[15:12]), decode.addr_mode);
		op_compare(exec_op_t'(v[10:4]), decode.exec_op);
		info_compare(access_info_t'(v[1:0]), decode.info);
		tally($sformatf("vector %0d opcode %h", idx, v[23:16]));
	endtask

	task automatic load_vectors();
		$readmemh("tb/opcode_stim.txt", vectors);
		// A mode nibble of f marks the end of the list
		while (n_vectors < max_vectors && vectors[n_vectors][15:12] != 4'hf)
			n_vectors++;
	endtask

	initial begin
		rst_n = 1'b0;
		opcode.raw = 8'h11;  // Decodes to none of the reset values
		load_vectors();
		cycle_limit = reset_cycles + 2 * n_vectors + 20;

		repeat (reset_cycles) @(negedge CLK);
		mismatches = 0;
		mode_compare(addr_none, decode.addr_mode);
		op_compare(op_nop, decode.exec_op);
		info_compare('0, decode.info);
		tally("reset");

		// Opcodes follow each other with no idle cycle
		rst_n = 1'b1;
		if (n_vectors == 0) begin
			$display("No vectors could be read from tb/opcode_stim.txt");
			fail_count++;
		end else begin
			opcode = opcode_u'(vectors[0][23:16]);
			for (int i = 1; i <= n_vectors; i++) begin
				@(negedge CLK);
				score_vector(i - 1);
				if (i < n_vectors)
					opcode = opcode_u'(vectors[i][23:16]);
			end
		end

		$display("%0d tests run, %0d passed, %0d failed",
			pass_count + fail_count, pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb/opcode_stim.txt */
// opcode_mode_operation_flags, all hex; flags are {mem_read, page_cross}
// A line with mode f ends the list
01_7_00_2
11_8_00_3
29_5_01_2
7d_2_03_3
91_8_04_0
f9_3_07_3
0a_0_0c_0
1e_2_08_2
96_b_10_0
be_3_11_3
6c_6_22_0
20_1_23_0
24_9_16_2
10_4_1f_3
d0_4_1e_3
f0_4_1c_3
00_0_19_0
48_0_28_0
9a_0_37_0
ea_0_3b_0
02_c_3c_0
89_c_3c_0
9e_c_3c_0
ff_c_3c_0
a9_5_05_2
a0_5_15_2
4c_1_22_0
c6_9_12_2
8d_1_04_0
bc_2_15_3
60_0_24_0
e0_5_18_2
2a_0_0d_0
b6_b_11_2
18_0_2e_0
ff_f_ff_f
